// File: verilog/isaPkg.sv
package isaPkg;

    // datapath and PC width
    parameter int dataWidth = 32;

    // register address width and the register count it implies
    parameter int regAddrWidth = 5;
    parameter int numRegs = 1 << regAddrWidth;

    // only the low bits of operand 2 take part in a shift
    parameter int shamtWidth = $clog2(dataWidth);

    // ALU operations carried by a decoded instruction
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,   // signed compare, result is 0 or 1
        ALU_SLL,
        ALU_LINK   // result is pcNext, as for a jump-and-link
    } aluOp;

endpackage

// File: verilog/pipePkg.sv
package pipePkg;

    // one decoded instruction as it leaves the decoder
    typedef struct packed {
        isaPkg::aluOp                      op;
        logic [isaPkg::regAddrWidth-1:0]   src1;
        logic [isaPkg::regAddrWidth-1:0]   src2;
        logic [isaPkg::regAddrWidth-1:0]   dest;
        logic [isaPkg::dataWidth-1:0]      imm;
        logic                              useImm;   // imm replaces register operand 2
        logic [isaPkg::dataWidth-1:0]      pc;
        logic [isaPkg::dataWidth-1:0]      pcNext;
    } decodedInstr;

    // what the writeback register holds and reports to the sink
    typedef struct packed {
        logic [isaPkg::regAddrWidth-1:0]   dest;
        logic [isaPkg::dataWidth-1:0]      data;
        logic [isaPkg::dataWidth-1:0]      pc;
    } execResult;

    // width of a counter that must hold every value from 0 up to maxCount
    function automatic int creditWidth(input int maxCount);
        return $clog2(maxCount + 1);
    endfunction

endpackage

// File: verilog/idExBundle.sv
`timescale 1ns/1ps

// contents of the execute stage, written by the ID/EX register
interface idExBundle;
    import isaPkg::*;
    import pipePkg::*;

    logic                 valid;   // stage holds a live instruction
    decodedInstr          instr;
    logic [dataWidth-1:0] rd1;     // register operands read in decode
    logic [dataWidth-1:0] rd2;

    // the pipeline register drives the stage
    modport source (
        output valid, instr, rd1, rd2
    );

    // the execute unit only looks at it
    modport sink (
        input valid, instr, rd1, rd2
    );

endinterface

// File: verilog/decodeQueue.sv
`timescale 1ns/1ps

module decodeQueue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 pushValid,
    input  pipePkg::decodedInstr pushInstr,
    input  logic                 pop,
    input  logic                 flush,
    output logic                 headValid,
    output pipePkg::decodedInstr headInstr,
    output logic                 instrCredit
);
    import pipePkg::*;

    localparam int ptrWidth = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int cntWidth = creditWidth(QUEUE_DEPTH);

    decodedInstr         slots [QUEUE_DEPTH];
    logic [ptrWidth-1:0] rdPtr;
    logic [ptrWidth-1:0] wrPtr;
    logic [cntWidth-1:0] count;
    logic [cntWidth-1:0] pendingCredits;   // freed slots not yet returned to the source
    logic [cntWidth-1:0] freedSlots;
    logic                doPush;
    logic                doPop;

    function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
        if (ptr == ptrWidth'(QUEUE_DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign headValid   = (count != '0);
    assign headInstr   = slots[rdPtr];
    assign instrCredit = (pendingCredits != '0);   // drained at one credit per cycle

    assign doPush = pushValid && (count < cntWidth'(QUEUE_DEPTH));
    assign doPop  = pop && headValid && !flush;

    // a flush empties the queue, and a push in the same cycle goes with it
    always_comb begin
        if (flush)
            freedSlots = count + cntWidth'(doPush);
        else
            freedSlots = cntWidth'(doPop);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdPtr          <= '0;
            wrPtr          <= '0;
            count          <= '0;
            pendingCredits <= '0;
        end else begin
            if (flush) begin
                rdPtr <= '0;
                wrPtr <= '0;
                count <= '0;
            end else begin
                if (doPush)
                    wrPtr <= nextPtr(wrPtr);
                if (doPop)
                    rdPtr <= nextPtr(rdPtr);
                count <= count + cntWidth'(doPush) - cntWidth'(doPop);
            end
            pendingCredits <= pendingCredits + freedSlots - cntWidth'(instrCredit);
        end
    end

    always_ff @(posedge clk) begin
        if (doPush && !flush)
            slots[wrPtr] <= pushInstr;
    end

    // the source only pushes on a credit it holds, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (reset)
        pushValid |-> count < cntWidth'(QUEUE_DEPTH))
        else $error("decodeQueue: push into a full queue");

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [isaPkg::regAddrWidth-1:0] rdAddr1,
    input  logic [isaPkg::regAddrWidth-1:0] rdAddr2,
    output logic [isaPkg::dataWidth-1:0]    rdData1,
    output logic [isaPkg::dataWidth-1:0]    rdData2,
    input  logic                            wrEnable,
    input  logic [isaPkg::regAddrWidth-1:0] wrAddr,
    input  logic [isaPkg::dataWidth-1:0]    wrData
);
    import isaPkg::*;

    logic [dataWidth-1:0] regs [numRegs];

    // read port logic, instantiated once for each operand
    function automatic logic [dataWidth-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        if (addr == '0)
            return '0;   // x0 always reads zero
        if (wrEnable && wrAddr == addr)
            return wrData;   // write-through, the reader sees this cycle's write
        return regs[addr];
    endfunction

    always_comb begin
        rdData1 = readPort(rdAddr1);
        rdData2 = readPort(rdAddr2);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end else if (wrEnable && wrAddr != '0) begin
            regs[wrAddr] <= wrData;   // writes to x0 are dropped
        end
    end

endmodule

// File: verilog/idExRegister.sv
`timescale 1ns/1ps

// decode to execute pipeline register
module idExRegister (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         stallE,
    input  logic                         flushE,
    input  logic                         headValid,
    input  pipePkg::decodedInstr         headInstr,
    input  logic [isaPkg::dataWidth-1:0] rd1,
    input  logic [isaPkg::dataWidth-1:0] rd2,
    idExBundle.source                    stage
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stage.valid <= 1'b0;
            stage.instr <= '0;
            stage.rd1   <= '0;
            stage.rd2   <= '0;
        end else if (flushE) begin
            // flush wins over stall and leaves a bubble
            stage.valid <= 1'b0;
            stage.instr <= '0;
            stage.rd1   <= '0;
            stage.rd2   <= '0;
        end else if (!stallE) begin
            stage.valid <= headValid;   // an empty queue head moves in as a bubble
            stage.instr <= headInstr;
            stage.rd1   <= rd1;
            stage.rd2   <= rd2;
        end
    end

    // whatever the stall says, a flushed stage is empty on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        flushE |=> !stage.valid)
        else $error("idExRegister: stage still valid after a flush");

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit (
    input  logic                            clk,
    input  logic                            reset,
    idExBundle.sink                         stage,
    input  logic                            advance,
    output logic                            wrEnable,
    output logic [isaPkg::regAddrWidth-1:0] wrAddr,
    output logic [isaPkg::dataWidth-1:0]    wrData,
    output pipePkg::execResult              result,
    output logic                            resultValid
);
    import isaPkg::*;
    import pipePkg::*;

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] regB;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluOut;
    logic                 fwdA;
    logic                 fwdB;
    logic                 fire;

    // forward from the writeback register when it targets a source register
    assign fwdA = resultValid && (result.dest != '0) && (result.dest == stage.instr.src1);
    assign fwdB = resultValid && (result.dest != '0) && (result.dest == stage.instr.src2);

    assign opA  = fwdA ? result.data : stage.rd1;
    assign regB = fwdB ? result.data : stage.rd2;
    assign opB  = stage.instr.useImm ? stage.instr.imm : regB;

    always_comb begin
        case (stage.instr.op)
            ALU_ADD:  aluOut = opA + opB;
            ALU_SUB:  aluOut = opA - opB;
            ALU_AND:  aluOut = opA & opB;
            ALU_OR:   aluOut = opA | opB;
            ALU_XOR:  aluOut = opA ^ opB;
            ALU_SLT:  aluOut = dataWidth'($signed(opA) < $signed(opB));
            ALU_SLL:  aluOut = opA << opB[shamtWidth-1:0];
            ALU_LINK: aluOut = stage.instr.pcNext;
            default:  aluOut = '0;
        endcase
    end

    assign fire = stage.valid && advance;   // only moves on while an output credit is left

    // the register file takes the result on the same edge as the writeback register
    assign wrEnable = fire;
    assign wrAddr   = stage.instr.dest;
    assign wrData   = aluOut;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            resultValid <= 1'b0;
        else
            resultValid <= fire;   // a single-cycle pulse per result
    end

    always_ff @(posedge clk) begin
        if (fire)
            result <= '{dest: stage.instr.dest, data: aluOut, pc: stage.instr.pc};
    end

endmodule

// File: verilog/pipeControl.sv
`timescale 1ns/1ps

module pipeControl #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic reset,
    input  logic flush,
    input  logic headValid,
    input  logic stageValid,
    input  logic resultCredit,
    input  logic resultValid,
    output logic stallE,
    output logic flushE,
    output logic popQueue,
    output logic advance
);
    import pipePkg::*;

    localparam int cntWidth = creditWidth(OUT_CREDITS);

    typedef enum logic {
        RUN,
        BLOCKED   // no output credit left
    } ctrlState;

    ctrlState            state;
    logic [cntWidth-1:0] creditCount;
    logic [cntWidth-1:0] creditNext;

    // the result now on the output already owns one of the counted credits
    assign creditNext = creditCount + cntWidth'(resultCredit) - cntWidth'(resultValid);

    assign advance  = (state == RUN) && (creditCount > cntWidth'(resultValid));
    assign stallE   = stageValid && !advance;
    assign popQueue = headValid && !stallE && !flush;
    assign flushE   = flush;   // a redirect only ever clears the execute stage

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            creditCount <= cntWidth'(OUT_CREDITS);
            state       <= (OUT_CREDITS > 0) ? RUN : BLOCKED;
        end else begin
            creditCount <= creditNext;
            state       <= (creditNext == '0) ? BLOCKED : RUN;
        end
    end

    // the sink never hands back more credits than it was given
    assert property (@(posedge clk) disable iff (reset)
        creditCount <= cntWidth'(OUT_CREDITS))
        else $error("pipeControl: output credit count above OUT_CREDITS");

endmodule

// File: verilog/execCore.sv
`timescale 1ns/1ps

module execCore #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            instrValid,
    input  isaPkg::aluOp                    instrOp,
    input  logic [isaPkg::regAddrWidth-1:0] instrSrc1,
    input  logic [isaPkg::regAddrWidth-1:0] instrSrc2,
    input  logic [isaPkg::regAddrWidth-1:0] instrDest,
    input  logic [isaPkg::dataWidth-1:0]    instrImm,
    input  logic                            instrUseImm,
    input  logic [isaPkg::dataWidth-1:0]    instrPc,
    input  logic [isaPkg::dataWidth-1:0]    instrPcNext,
    output logic                            instrCredit,
    output logic                            resultValid,
    output logic [isaPkg::regAddrWidth-1:0] resultDest,
    output logic [isaPkg::dataWidth-1:0]    resultData,
    output logic [isaPkg::dataWidth-1:0]    resultPc,
    input  logic                            resultCredit,
    input  logic                            flush
);
    import isaPkg::*;
    import pipePkg::*;

    decodedInstr             pushInstr;
    decodedInstr             headInstr;
    execResult               result;
    logic                    headValid;
    logic                    stallE;
    logic                    flushE;
    logic                    popQueue;
    logic                    advance;
    logic [dataWidth-1:0]    rd1;
    logic [dataWidth-1:0]    rd2;
    logic                    wrEnable;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    wrData;

    idExBundle stageBus ();

    assign pushInstr = '{op: instrOp, src1: instrSrc1, src2: instrSrc2, dest: instrDest,
                         imm: instrImm, useImm: instrUseImm, pc: instrPc,
                         pcNext: instrPcNext};

    assign resultDest = result.dest;
    assign resultData = result.data;
    assign resultPc   = result.pc;

    decodeQueue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue (
        .clk         (clk),
        .reset       (reset),
        .pushValid   (instrValid),
        .pushInstr   (pushInstr),
        .pop         (popQueue),
        .flush       (flush),
        .headValid   (headValid),
        .headInstr   (headInstr),
        .instrCredit (instrCredit)
    );

    // operands are read for the queue head, just before it enters execute
    registerFile regFile (
        .clk      (clk),
        .reset    (reset),
        .rdAddr1  (headInstr.src1),
        .rdAddr2  (headInstr.src2),
        .rdData1  (rd1),
        .rdData2  (rd2),
        .wrEnable (wrEnable),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

    idExRegister idEx (
        .clk       (clk),
        .reset     (reset),
        .stallE    (stallE),
        .flushE    (flushE),
        .headValid (headValid),
        .headInstr (headInstr),
        .rd1       (rd1),
        .rd2       (rd2),
        .stage     (stageBus.source)
    );

    executeUnit execute (
        .clk         (clk),
        .reset       (reset),
        .stage       (stageBus.sink),
        .advance     (advance),
        .wrEnable    (wrEnable),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .result      (result),
        .resultValid (resultValid)
    );

    pipeControl #(
        .OUT_CREDITS(OUT_CREDITS)
    ) control (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .headValid    (headValid),
        .stageValid   (stageBus.valid),
        .resultCredit (resultCredit),
        .resultValid  (resultValid),
        .stallE       (stallE),
        .flushE       (flushE),
        .popQueue     (popQueue),
        .advance      (advance)
    );

endmodule

// File: testbench/execCoreTb.sv
`timescale 1ns/1ps

module execCoreTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int QUEUE_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int CLK_PERIOD  = 10;
    localparam int NUM_TESTS   = 5;

    typedef logic [regAddrWidth-1:0] regIdx;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 instrValid;
    aluOp                 instrOp;
    regIdx                instrSrc1;
    regIdx                instrSrc2;
    regIdx                instrDest;
    logic [dataWidth-1:0] instrImm;
    logic                 instrUseImm;
    logic [dataWidth-1:0] instrPc;
    logic [dataWidth-1:0] instrPcNext;
    logic                 instrCredit;
    logic                 resultValid;
    regIdx                resultDest;
    logic [dataWidth-1:0] resultData;
    logic [dataWidth-1:0] resultPc;
    logic                 resultCredit;
    logic                 flush;

    logic                 holdCredits;     // sink keeps its credits while set
    int                   seed = 80;
    int                   sourceCredits;   // credits the source holds for the decode queue
    int                   owedCredits;     // results the sink has taken but not yet credited
    int                   sentCount;
    int                   creditPulses;
    int                   resultCount;
    logic [dataWidth-1:0] mirror [numRegs];   // architectural registers in program order
    logic [dataWidth-1:0] pcCounter;
    execResult            expected [$];

    execCore #(
        .QUEUE_DEPTH(QUEUE_DEPTH),
        .OUT_CREDITS(OUT_CREDITS)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .instrValid   (instrValid),
        .instrOp      (instrOp),
        .instrSrc1    (instrSrc1),
        .instrSrc2    (instrSrc2),
        .instrDest    (instrDest),
        .instrImm     (instrImm),
        .instrUseImm  (instrUseImm),
        .instrPc      (instrPc),
        .instrPcNext  (instrPcNext),
        .instrCredit  (instrCredit),
        .resultValid  (resultValid),
        .resultDest   (resultDest),
        .resultData   (resultData),
        .resultPc     (resultPc),
        .resultCredit (resultCredit),
        .flush        (flush)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkResult(input execResult got, input execResult exp);
        if (got !== exp)
            failRun($sformatf(
                "CHECK FAILED at %0t: got x%0d data %h pc %h, expected x%0d data %h pc %h",
                $time, got.dest, got.data, got.pc, exp.dest, exp.data, exp.pc));
    endtask

    task automatic checkCount(input int got, input int exp, input string what);
        if (got != exp)
            failRun($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                              $time, what, got, exp));
    endtask

    // reference ALU, straight from the opcode definitions
    function automatic logic [dataWidth-1:0] aluModel(input aluOp op, input logic [31:0] a,
                                                      input logic [31:0] b,
                                                      input logic [31:0] linkAddr);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLL:  return a << b[4:0];
            ALU_LINK: return linkAddr;
            default:  return '0;
        endcase
    endfunction

    // outputs are sampled on the falling edge, away from the driving edge
    always @(negedge clk) begin : monitor
        execResult got;
        if (!reset) begin
            if (instrCredit) begin
                creditPulses++;
                sourceCredits++;
            end
            if (resultValid) begin
                resultCount++;
                owedCredits++;
                got.dest = resultDest;
                got.data = resultData;
                got.pc   = resultPc;
                if (expected.size() == 0)
                    failRun($sformatf("unexpected result for x%0d at %0t", resultDest, $time));
                else
                    checkResult(got, expected.pop_front());
            end
        end
    end

    // the sink hands back one credit per cycle for every result it took
    initial begin
        resultCredit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (!reset && !holdCredits && owedCredits > 0) begin
                resultCredit = 1'b1;
                owedCredits--;
            end else begin
                resultCredit = 1'b0;
            end
        end
    end

    task automatic pushInstr(input decodedInstr d);
        while (sourceCredits == 0) begin
            @(posedge clk);
            #1;
        end
        sourceCredits--;
        sentCount++;
        instrValid  = 1'b1;
        instrOp     = d.op;
        instrSrc1   = d.src1;
        instrSrc2   = d.src2;
        instrDest   = d.dest;
        instrImm    = d.imm;
        instrUseImm = d.useImm;
        instrPc     = d.pc;
        instrPcNext = d.pcNext;
        @(posedge clk);
        #1;
        instrValid = 1'b0;
    endtask

    // a LINK carries its target in imm, which makes it a register load
    task automatic issue(input aluOp op, input regIdx src1, input regIdx src2, input regIdx dest,
                         input logic [dataWidth-1:0] imm, input logic useImm,
                         input logic retires);
        decodedInstr          d;
        execResult            exp;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        d.op     = op;
        d.src1   = src1;
        d.src2   = src2;
        d.dest   = dest;
        d.imm    = imm;
        d.useImm = useImm;
        d.pc     = pcCounter;
        d.pcNext = (op == ALU_LINK) ? imm : pcCounter + 32'd4;
        pcCounter = pcCounter + 32'd4;
        if (retires) begin
            a = mirror[src1];
            b = useImm ? imm : mirror[src2];
            exp.dest = dest;
            exp.data = aluModel(op, a, b, d.pcNext);
            exp.pc   = d.pc;
            expected.push_back(exp);
            if (dest != 0)
                mirror[dest] = exp.data;   // x0 reports its data but keeps zero
        end
        pushInstr(d);
    endtask

    task automatic waitForResults(input int target);
        int waited;
        waited = 0;
        while (resultCount < target && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (resultCount < target)
            failRun("timed out waiting for results from the DUT");
    endtask

    task automatic drainResults();
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (expected.size() != 0)
            failRun("timed out with results still missing from the DUT");
    endtask

    // every credit on both sides back with its owner
    task automatic waitIdle();
        int waited;
        waited = 0;
        while ((owedCredits != 0 || sourceCredits != QUEUE_DEPTH) && waited < 100) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (owedCredits != 0 || sourceCredits != QUEUE_DEPTH)
            failRun("timed out waiting for the credits to come back");
    endtask

    // a result here finds no expected entry in the monitor
    task automatic idleAfterReset();
        repeat (5) @(posedge clk);
        #1;
        checkCount(creditPulses, 0, "input credits after reset");
    endtask

    task automatic aluOperations();
        aluOp ops [7];
        ops = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL};
        for (int r = 1; r < 8; r++)
            issue(ALU_LINK, 0, 0, regIdx'(r), $random(seed), 1'b1, 1'b1);
        foreach (ops[i]) begin
            issue(ops[i], regIdx'(i + 1), regIdx'(i + 2), regIdx'(10 + i), 0, 1'b0, 1'b1);
            issue(ops[i], regIdx'(i + 1), 0, regIdx'(20 + i), $random(seed), 1'b1, 1'b1);
        end
        issue(ALU_ADD, 1, 0, 0, 32'h1234, 1'b1, 1'b1);   // x0 write still reports its data
        issue(ALU_OR, 0, 0, 9, 0, 1'b0, 1'b1);
        issue(ALU_ADD, 0, 0, 8, 32'h55, 1'b1, 1'b1);
        drainResults();
    endtask

    task automatic forwardingChains();
        for (int round = 0; round < 2; round++) begin
            issue(ALU_ADD, 1, 2, 11, 0, 1'b0, 1'b1);
            issue(ALU_SUB, 11, 3, 12, 0, 1'b0, 1'b1);   // distance 1 on operand 1
            issue(ALU_XOR, 4, 12, 13, 0, 1'b0, 1'b1);   // distance 1 on operand 2
            issue(ALU_ADD, 5, 0, 14, $random(seed), 1'b1, 1'b1);
            issue(ALU_OR, 6, 7, 15, 0, 1'b0, 1'b1);
            issue(ALU_SLL, 14, 13, 16, 0, 1'b0, 1'b1);   // distance 2 and 3
            issue(ALU_AND, 1, 2, 17, 0, 1'b0, 1'b1);
            issue(ALU_ADD, 3, 0, 18, $random(seed), 1'b1, 1'b1);
            issue(ALU_SLT, 18, 15, 19, 0, 1'b0, 1'b1);
            issue(ALU_XOR, 17, 19, 20, 0, 1'b0, 1'b1);   // distance 3 against distance 1
            issue(ALU_ADD, 20, 11, 1, 0, 1'b0, 1'b1);
        end
        drainResults();
    endtask

    task automatic outputBackPressure();
        int start;
        waitIdle();
        holdCredits = 1'b1;
        start = resultCount;
        issue(ALU_ADD, 1, 2, 3, 0, 1'b0, 1'b1);
        issue(ALU_SUB, 3, 4, 5, 0, 1'b0, 1'b1);
        issue(ALU_XOR, 5, 0, 6, $random(seed), 1'b1, 1'b1);
        issue(ALU_OR, 6, 3, 7, 0, 1'b0, 1'b1);
        waitForResults(start + OUT_CREDITS);
        repeat (20) @(posedge clk);
        #1;
        checkCount(resultCount - start, OUT_CREDITS, "results with output credits withheld");
        holdCredits = 1'b0;
        drainResults();
    endtask

    task automatic flushFullQueue();
        int start;
        waitIdle();
        holdCredits = 1'b1;
        start = resultCount;
        issue(ALU_ADD, 1, 2, 21, 0, 1'b0, 1'b1);
        issue(ALU_XOR, 3, 0, 22, $random(seed), 1'b1, 1'b1);
        // one stalls in execute and four fill the queue, none of them retire
        for (int k = 0; k < 5; k++)
            issue(ALU_LINK, 0, 0, regIdx'(23 + k), $random(seed), 1'b1, 1'b0);
        waitForResults(start + OUT_CREDITS);
        repeat (3) @(posedge clk);
        #1;
        checkCount(sourceCredits, 0, "source credits with a full queue");
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        holdCredits = 1'b0;
        // the flushed slots come back one per cycle, well inside this window
        repeat (20) @(posedge clk);
        #1;
        checkCount(creditPulses, sentCount, "input credits returned");
        waitIdle();
        for (int k = 0; k < 5; k++)
            issue(ALU_OR, regIdx'(23 + k), regIdx'(23 + k), regIdx'(23 + k), 0, 1'b0, 1'b1);
        drainResults();
    endtask

    initial begin
        reset         = 1'b1;
        instrValid    = 1'b0;
        instrOp       = ALU_ADD;
        instrSrc1     = '0;
        instrSrc2     = '0;
        instrDest     = '0;
        instrImm      = '0;
        instrUseImm   = 1'b0;
        instrPc       = '0;
        instrPcNext   = '0;
        flush         = 1'b0;
        holdCredits   = 1'b0;
        sourceCredits = QUEUE_DEPTH;
        owedCredits   = 0;
        sentCount     = 0;
        creditPulses  = 0;
        resultCount   = 0;
        pcCounter     = 32'h100;
        foreach (mirror[i])
            mirror[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        idleAfterReset();
        aluOperations();
        forwardingChains();
        outputBackPressure();
        flushFullQueue();
        waitIdle();
        $display("TESTBENCH PASSED");
        $finish;
    end

    // each test gets 200 cycles, plus the reset time
    initial begin
        #((NUM_TESTS * 200 + 10) * CLK_PERIOD);
        failRun("watchdog expired, the DUT stopped making progress");
    end

endmodule

// File: list.f
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/idExBundle.sv
verilog/decodeQueue.sv
verilog/registerFile.sv
verilog/idExRegister.sv
verilog/executeUnit.sv
verilog/pipeControl.sv
verilog/execCore.sv
testbench/execCoreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module execCoreTb -f list.f -o execCoreSim &&
./obj_dir/execCoreSim ||
{ echo "simulation failed"; exit 1; }
